// ==== filelist.f ====
+incdir+hw
hw/row_buffer_pkg.sv
hw/awe_ctrl_pkg.sv
hw/pixel_bank_ram.sv
hw/row_buffer_delay.sv
hw/seq_read_ctrl.sv
hw/bank_write_ctrl.sv
hw/row_buffer_top.sv
verif/row_buffer_checker.sv
verif/row_buffer_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = row_buffer_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/row_buffer_tb.sv ====
module row_buffer_tb
    import row_buffer_pkg::*;
    import awe_ctrl_pkg::*;
();

    // One row of the stimulus table
    typedef struct packed {
        awe_state_e  state;
        gray_t       gray;
        col_t        row;
        col_t        col;
        col_t        ncols;
        logic        pfb;
        logic        exec;
        logic [11:0] seq;
        logic        mat;
        col_t        mat_addr;
        logic        last;
    } step_t;

    logic          clk;
    logic          rst;
    awe_state_e    state;
    gray_t         gray_code;
    col_t          input_row;
    col_t          input_col;
    col_t          num_input_cols;
    logic          pfb_rden;
    pixel_t        pixel_datain;
    logic          execute;
    pix_seq_word_u pix_seq_datain;
    logic          last_kernel;
    logic          row_matric;
    col_t          row_matric_wr_addr;
    bank_pair_t    pixel_dataout;
    logic          pixel_dataout_valid;

    step_t        steps[$];
    bank_pair_t   exp_q[$];
    pixel_t       shadow_even [64];
    pixel_t       shadow_odd [64];
    row_mat_req_t mat_pipe [3];
    integer       seed;
    int           mismatches;
    int           other_errors;
    int           reads_checked;

    row_buffer_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Odd low bit lands in the parity field or in the low field
    function automatic logic [11:0] seq_word(input logic half, input int ecol, input int ocol,
                                             input logic use_par);
        col_t oc;
        oc = col_t'(ocol);
        seq_word = {half, col_t'(ecol), oc[4:1], oc[0] & use_par, oc[0] & ~use_par};
    endfunction

    task automatic add_step(input awe_state_e st, input gray_t g, input int row, input int col,
                            input logic pfb, input logic ex, input logic [11:0] seq,
                            input logic mat, input int maddr, input logic last);
        step_t s;
        s.state = st;
        s.gray = g;
        s.row = col_t'(row);
        s.col = col_t'(col);
        s.ncols = 5'd3;
        s.pfb = pfb;
        s.exec = ex;
        s.seq = seq;
        s.mat = mat;
        s.mat_addr = col_t'(maddr);
        s.last = last;
        steps.push_back(s);
    endtask

    task automatic idle_steps(input awe_state_e st, input gray_t g, input logic last, input int n);
        repeat (n) add_step(st, g, 0, 0, 1'b0, 1'b0, 12'h000, 1'b0, 0, last);
    endtask

    // Back-to-back reads over every written column of both halves
    task automatic read_sweep(input gray_t g);
        for (int c = 0; c < 5; c++) begin
            for (int h = 0; h < 2; h++) begin
                add_step(ST_CE_ACTIVE, g, 0, 0, 1'b0, 1'b1, seq_word(h[0], c, 4 - c, h[0]),
                         1'b0, 0, 1'b0);
            end
        end
    endtask

    task automatic build_table();
        // Column 4 under a wider bound first, so a later stray write shows up
        for (int r = 0; r < 3; r++) begin
            add_step(ST_PRIM_BUFFER, 2'b00, r, 4, 1'b1, 1'b0, 12'h000, 1'b0, 0, 1'b0);
            steps[steps.size()-1].ncols = 5'd4;
        end
        // Row 3 and column 4 write nothing
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 5; c++) begin
                add_step(ST_PRIM_BUFFER, 2'b00, r, c, 1'b1, 1'b0, 12'h000, 1'b0, 0, 1'b0);
            end
        end
        add_step(ST_PRIM_BUFFER, 2'b00, 0, 2, 1'b0, 1'b0, 12'h000, 1'b0, 0, 1'b0);
        idle_steps(ST_WAIT_PFB_LOAD, 2'b00, 1'b0, 2);
        read_sweep(2'b00);
        // Second priming pass
        idle_steps(ST_IDLE, 2'b00, 1'b0, 2);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 4; c++) begin
                add_step(ST_PRIM_BUFFER, 2'b00, r, c, 1'b1, 1'b0, 12'h000, 1'b0, 0, 1'b0);
            end
        end
        idle_steps(ST_WAIT_PFB_LOAD, 2'b00, 1'b0, 2);
        for (int g = 0; g < 4; g++) begin
            read_sweep(gray_t'(g));
        end
        // Matriculation under each gray code
        for (int g = 0; g < 4; g++) begin
            add_step(ST_CE_ACTIVE, gray_t'(g), 0, 0, 1'b0, 1'b0, 12'h000, 1'b1, g, 1'b1);
            idle_steps(ST_CE_ACTIVE, gray_t'(g), 1'b1, 6);
            read_sweep(gray_t'(g));
        end
        // Requests that must leave the banks alone
        add_step(ST_CE_ACTIVE, 2'b00, 0, 0, 1'b0, 1'b0, 12'h000, 1'b1, 1, 1'b0);
        idle_steps(ST_CE_ACTIVE, 2'b00, 1'b0, 6);
        add_step(ST_WAIT_PFB_LOAD, 2'b00, 0, 0, 1'b0, 1'b0, 12'h000, 1'b1, 2, 1'b1);
        idle_steps(ST_WAIT_PFB_LOAD, 2'b00, 1'b1, 6);
        for (int g = 0; g < 4; g++) begin
            read_sweep(gray_t'(g));
        end
    endtask

    task automatic drive(input step_t s, input pixel_t pix);
        state = s.state;
        gray_code = s.gray;
        input_row = s.row;
        input_col = s.col;
        num_input_cols = s.ncols;
        pfb_rden = s.pfb;
        pixel_datain = pix;
        execute = s.exec;
        pix_seq_datain = s.seq;
        row_matric = s.mat;
        row_matric_wr_addr = s.mat_addr;
        last_kernel = s.last;
    endtask

    // Drive one step and update the bank model by the write rules
    task automatic apply_step(input step_t s);
        row_mat_req_t arrived;
        bank_addr_t   ea;
        bank_addr_t   oa;
        pixel_t       pix;
        pix = pixel_t'($random(seed));
        @(posedge clk);
        #2;
        drive(s, pix);
        if (s.exec && s.state == ST_CE_ACTIVE) begin
            ea = {s.gray[0] ^ s.seq[11], s.seq[10:6]};
            oa = {s.gray[1] ^ s.seq[11], s.seq[5:2], s.seq[1] | s.seq[0]};
            exp_q.push_back({shadow_odd[oa], shadow_even[ea]});
        end
        if (s.state == ST_PRIM_BUFFER && s.pfb && s.col <= s.ncols) begin
            if (s.row == 5'd0) begin
                shadow_even[{1'b0, s.col}] = pix;
                shadow_odd[{1'b0, s.col}] = pix;
            end else if (s.row == 5'd1) begin
                shadow_odd[{1'b1, s.col}] = pix;
            end else if (s.row == 5'd2) begin
                shadow_even[{1'b1, s.col}] = pix;
            end
        end
        // Request from three steps back meets this step's controls
        arrived = mat_pipe[2];
        mat_pipe[2] = mat_pipe[1];
        mat_pipe[1] = mat_pipe[0];
        mat_pipe[0] = {s.mat, s.mat_addr, pix};
        if (s.state == ST_CE_ACTIVE && arrived.row_matric && s.last) begin
            if (s.gray[0] == s.gray[1]) begin
                shadow_odd[{s.gray[0], arrived.wr_addr}] = arrived.pixel;
            end else begin
                shadow_even[{s.gray[0], arrived.wr_addr}] = arrived.pixel;
            end
        end
    endtask

    always @(negedge clk) begin
        bank_pair_t expected;
        if (!rst && pixel_dataout_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("Valid at time %0t with no read pending", $time);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                reads_checked++;
                assert (pixel_dataout === expected) else begin
                    $display("MISMATCH time=%0t signal=pixel_dataout expected=%h actual=%h",
                             $time, expected, pixel_dataout);
                    mismatches++;
                end
            end
        end
    end

    initial begin
        step_t rest_step;
        int    drain;
        seed = 32'h4126a431;
        mismatches = 0;
        other_errors = 0;
        reads_checked = 0;
        rest_step = '0;
        rest_step.state = ST_IDLE;
        rst = 1'b1;
        drive(rest_step, '0);
        foreach (mat_pipe[i]) begin
            mat_pipe[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        @(posedge clk);
        #2;
        drive(rest_step, '0);
        for (drain = 0; drain < 20 && exp_q.size() != 0; drain++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d reads never came back with valid", exp_q.size());
            other_errors++;
        end
        repeat (4) @(posedge clk);
        // Failures of the bound assertions
        other_errors += dut0.chk0.fail_count;
        $display("Errors: %0d mismatches, %0d other, %0d reads checked",
                 mismatches, other_errors, reads_checked);
        if (mismatches == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verif/row_buffer_checker.sv ====
module row_buffer_checker
    import awe_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input awe_state_e state,
    input logic       execute,
    input logic       wren_even,
    input logic       wren_odd,
    input logic       valid
);

    int fail_count = 0;

    valid_after_reset: assert property (@(posedge clk) rst |=> !valid)
        else begin
            $error("pixel_dataout_valid high in the cycle after reset");
            fail_count++;
        end

    // Enables are registered, so they follow the previous state
    write_in_state: assert property (@(posedge clk) disable iff (rst)
        (wren_even || wren_odd) |-> ($past(state) inside {ST_PRIM_BUFFER, ST_CE_ACTIVE}))
        else begin
            $error("bank write enable high outside priming and active states");
            fail_count++;
        end

    read_to_valid: assert property (@(posedge clk) disable iff (rst)
        (execute && state == ST_CE_ACTIVE) |-> ##3 valid)
        else begin
            $error("pixel_dataout_valid missing three cycles after execute");
            fail_count++;
        end

    valid_from_read: assert property (@(posedge clk) disable iff (rst)
        valid |-> $past(execute && state == ST_CE_ACTIVE, 3))
        else begin
            $error("pixel_dataout_valid without an execute three cycles before");
            fail_count++;
        end

endmodule

bind row_buffer_top row_buffer_checker chk0 (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .execute   (execute),
    .wren_even (wr_even.wren),
    .wren_odd  (wr_odd.wren),
    .valid     (pixel_dataout_valid)
);

// ==== hw/row_buffer_top.sv ====
module row_buffer_top
    import row_buffer_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  awe_state_e    state,
    input  gray_t         gray_code,
    input  col_t          input_row,
    input  col_t          input_col,
    input  col_t          num_input_cols,
    input  logic          pfb_rden,
    input  pixel_t        pixel_datain,
    input  logic          execute,
    input  pix_seq_word_u pix_seq_datain,
    input  logic          last_kernel,
    input  logic          row_matric,
    input  col_t          row_matric_wr_addr,
    output bank_pair_t    pixel_dataout,
    output logic          pixel_dataout_valid
);

    `include "rowbuf_defs.svh"

    bank_wr_t     wr_even;
    bank_wr_t     wr_odd;
    logic         rd_en;
    bank_addr_t   rd_addr_even;
    bank_addr_t   rd_addr_odd;
    row_mat_req_t row_mat_req;
    row_mat_req_t row_mat_req_d;
    pixel_t       dout_even;
    pixel_t       dout_odd;

    ////////////////////////////////////////////////////////////////////////////
    // Matriculation request, delayed as one word
    ////////////////////////////////////////////////////////////////////////////

    assign row_mat_req.row_matric = row_matric;
    assign row_mat_req.wr_addr    = row_matric_wr_addr;
    assign row_mat_req.pixel      = pixel_datain;

    row_buffer_delay #(
        .WIDTH ($bits(row_mat_req_t)),
        .DEPTH (`ROW_MAT_DELAY)
    ) row_mat_delay (
        .clk      (clk),
        .rst      (rst),
        .data_in  (row_mat_req),
        .data_out (row_mat_req_d)
    );

    bank_write_ctrl write_ctrl (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .gray_code      (gray_code),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pfb_rden       (pfb_rden),
        .pixel_datain   (pixel_datain),
        .last_kernel    (last_kernel),
        .row_mat        (row_mat_req_d),
        .wr_even        (wr_even),
        .wr_odd         (wr_odd)
    );

    seq_read_ctrl read_ctrl (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .gray_code      (gray_code),
        .execute        (execute),
        .pix_seq_datain (pix_seq_datain),
        .rden           (rd_en),
        .rd_addr_even   (rd_addr_even),
        .rd_addr_odd    (rd_addr_odd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Banks and output
    ////////////////////////////////////////////////////////////////////////////

    pixel_bank_ram bank_even (
        .clk     (clk),
        .wr      (wr_even),
        .rden    (rd_en),
        .rd_addr (rd_addr_even),
        .dataout (dout_even)
    );

    pixel_bank_ram bank_odd (
        .clk     (clk),
        .wr      (wr_odd),
        .rden    (rd_en),
        .rd_addr (rd_addr_odd),
        .dataout (dout_odd)
    );

    // Valid follows the bank read latency
    row_buffer_delay #(
        .WIDTH (1),
        .DEPTH (`RD_LATENCY)
    ) valid_delay (
        .clk      (clk),
        .rst      (rst),
        .data_in  (rd_en),
        .data_out (pixel_dataout_valid)
    );

    assign pixel_dataout.odd  = dout_odd;
    assign pixel_dataout.even = dout_even;

endmodule

// ==== hw/bank_write_ctrl.sv ====
module bank_write_ctrl
    import row_buffer_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  awe_state_e   state,
    input  gray_t        gray_code,
    input  col_t         input_row,
    input  col_t         input_col,
    input  col_t         num_input_cols,
    input  logic         pfb_rden,
    input  pixel_t       pixel_datain,
    input  logic         last_kernel,
    input  row_mat_req_t row_mat,
    output bank_wr_t     wr_even,
    output bank_wr_t     wr_odd
);

    logic       prim_ok;
    logic       mat_ok;
    bank_addr_t mat_addr;

    assign prim_ok  = pfb_rden && (input_col <= num_input_cols);
    assign mat_ok   = row_mat.row_matric && last_kernel;
    assign mat_addr = {gray_code[0], row_mat.wr_addr};

    ////////////////////////////////////////////////////////////////////////////
    // Write enables
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_even.wren <= 1'b0;
            wr_odd.wren  <= 1'b0;
        end else begin
            wr_even.wren <= 1'b0;
            wr_odd.wren  <= 1'b0;
            case (state)
                ST_PRIM_BUFFER: begin
                    if (prim_ok) begin
                        // Row 0 into both low halves, rows 1 and 2 split high
                        wr_even.wren <= (input_row == 5'd0) || (input_row == 5'd2);
                        wr_odd.wren  <= (input_row == 5'd0) || (input_row == 5'd1);
                    end
                end
                ST_CE_ACTIVE: begin
                    if (mat_ok) begin
                        wr_odd.wren  <= gray_code[0] == gray_code[1];
                        wr_even.wren <= gray_code[0] != gray_code[1];
                    end
                end
                default: begin
                    wr_even.wren <= 1'b0;
                    wr_odd.wren  <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write address and data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_CE_ACTIVE) begin
            wr_even.addr <= mat_addr;
            wr_odd.addr  <= mat_addr;
            wr_even.data <= row_mat.pixel;
            wr_odd.data  <= row_mat.pixel;
        end else begin
            // Half 1 only for rows 1 and 2
            wr_even.addr <= {input_row != 5'd0, input_col};
            wr_odd.addr  <= {input_row != 5'd0, input_col};
            wr_even.data <= pixel_datain;
            wr_odd.data  <= pixel_datain;
        end
    end

endmodule

// ==== hw/seq_read_ctrl.sv ====
module seq_read_ctrl
    import row_buffer_pkg::*;
    import awe_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  awe_state_e    state,
    input  gray_t         gray_code,
    input  logic          execute,
    input  pix_seq_word_u pix_seq_datain,
    output logic          rden,
    output bank_addr_t    rd_addr_even,
    output bank_addr_t    rd_addr_odd
);

    bank_addr_t addr_even;
    bank_addr_t addr_odd;

    // Gray code swaps the halves that hold the window rows
    assign addr_even = {gray_code[0] ^ pix_seq_datain.even.half, pix_seq_datain.even.col};
    assign addr_odd  = {gray_code[1] ^ pix_seq_datain.odd.half,
                        pix_seq_datain.odd.col_hi,
                        pix_seq_datain.odd.low | pix_seq_datain.odd.parity};

    always_ff @(posedge clk) begin
        if (rst) begin
            rden <= 1'b0;
        end else begin
            rden <= execute && (state == ST_CE_ACTIVE);
        end
    end

    always_ff @(posedge clk) begin
        if (execute && (state == ST_CE_ACTIVE)) begin
            rd_addr_even <= addr_even;
            rd_addr_odd  <= addr_odd;
        end
    end

endmodule

// ==== hw/row_buffer_delay.sv ====
module row_buffer_delay #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_out = stage[DEPTH-1];

endmodule

// ==== hw/pixel_bank_ram.sv ====
module pixel_bank_ram
    import row_buffer_pkg::*;
(
    input  logic       clk,
    input  bank_wr_t   wr,
    input  logic       rden,
    input  bank_addr_t rd_addr,
    output pixel_t     dataout
);

    `include "rowbuf_defs.svh"

    pixel_t mem [`BANK_DEPTH];
    pixel_t mem_q;
    pixel_t dout_q;

    always_ff @(posedge clk) begin
        if (wr.wren) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Memory register then output register, holds while rden is low
    always_ff @(posedge clk) begin
        if (rden) begin
            mem_q <= mem[rd_addr];
        end
        dout_q <= mem_q;
    end

    assign dataout = dout_q;

endmodule

// ==== hw/awe_ctrl_pkg.sv ====
package awe_ctrl_pkg;

    `include "rowbuf_defs.svh"

    import row_buffer_pkg::*;

    // One-hot window engine state
    typedef enum logic [4:0] {
        ST_IDLE          = 5'b00001,
        ST_PRIM_BUFFER   = 5'b00010,
        ST_WAIT_PFB_LOAD = 5'b00100,
        ST_CE_ACTIVE     = 5'b01000,
        ST_JOB_DONE      = 5'b10000
    } awe_state_e;

    // Which rows currently sit in which bank half
    typedef logic [1:0] gray_t;

    typedef struct packed {
        logic       half;
        col_t       col;
        logic [5:0] pad;
    } seq_even_t;

    typedef struct packed {
        logic       half;
        logic [4:0] pad;
        logic [3:0] col_hi;
        logic       parity;
        logic       low;
    } seq_odd_t;

    // Same sequence word, seen once per bank
    typedef union packed {
        seq_even_t even;
        seq_odd_t  odd;
    } pix_seq_word_u;

    // Incoming pixel of the next row, travels through one delay line
    typedef struct packed {
        logic   row_matric;
        col_t   wr_addr;
        pixel_t pixel;
    } row_mat_req_t;

endpackage

// ==== hw/row_buffer_pkg.sv ====
package row_buffer_pkg;

    `include "rowbuf_defs.svh"

    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`COL_W-1:0] col_t;

    // Top bit picks the bank half, low bits are the column
    typedef logic [`BANK_ADDR_W-1:0] bank_addr_t;

    // One write request into a single bank
    typedef struct packed {
        logic       wren;
        bank_addr_t addr;
        pixel_t     data;
    } bank_wr_t;

    // Window output, odd bank in the upper half
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } bank_pair_t;

endpackage

// ==== hw/rowbuf_defs.svh ====
`ifndef ROWBUF_DEFS_SVH
`define ROWBUF_DEFS_SVH

// Pixel and bank geometry
`define PIXEL_WIDTH 16
`define BANK_DEPTH 64
`define BANK_ADDR_W 6

// Row and column index width, one bit less than a bank address
`define COL_W 5

// Pixel-sequence word from the sequence memory
`define SEQ_WORD_W 12

// Pipeline depths
`define RD_LATENCY 2
`define ROW_MAT_DELAY 3

`endif
